//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_ddr_rd_chan
FILELIST = project.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = Done: no errors

SIM_BIN  = $(OBJDIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- project.f
source/ddr_rd_pkg.sv
source/ram_512x64w_1kx32r.sv
source/mcntrl_1kx32r.sv
source/ddr_rd_burst_seq.sv
source/ddr_rd_chan.sv
sim/tb_ddr_rd_chan.sv

//--- sim/ddr_rd_stim.txt
# read channel buffer stimulus, one operation per line
# T name             start of a test
# C page count       read command, count is 1 to 4 pages
# B count base       beats (count dec, base hex), beat k = {base+k, ~(base+k)} as hi, lo
# R addr word regen  read hex addr, expect hex word; regen 0 expects the held output
# S ready ovr busy   page_ready hex, overrun, busy
# L page             release a page

T reset_state
S 0 0 0
R 000 00000000 0

T single_page_p2
C 2 1
B 128 10000000
S 4 0 0
R 200 efffffff 1
R 201 10000000 1
R 202 effffffe 1
R 203 10000001 1
R 240 efffffdf 1
R 281 10000040 1
R 2fe efffff80 1
R 2ff 1000007f 1
L 2
S 0 0 0

T wrap_four_pages
C 3 4
B 512 40000000
S f 0 0
R 300 bfffffff 1
R 3ff 4000007f 1
R 000 bfffff7f 1
R 001 40000080 1
R 10b 40000105 1
R 1fe bffffe80 1
R 200 bffffe7f 1
R 2ff 400001ff 1

T read_latency
R 301 40000000 1
R 000 40000000 0
R 2ff 40000000 0
R 000 bfffff7f 1

T release_named_bit
L 0
S e 0 0
L 3
S 6 0 0
C 0 1
B 128 60000000
S 7 0 0
R 003 60000001 1

T overrun_sticky
C 1 1
B 128 70000000
S 7 1 0
R 100 8fffffff 1
R 1fd 7000007e 1
C 3 1
B 128 80000000
S f 1 0
R 3a4 7fffffad 1

//--- sim/tb_ddr_rd_chan.sv
`timescale 1ns/1ps

module tb_ddr_rd_chan
    import ddr_rd_pkg::*;
();

    localparam int CLK_NS = 40;                   // wclk period

    logic                 wclk;
    logic                 rst_n;
    logic                 cmd_start;
    logic [PAGE_W-1:0]    cmd_page;
    logic [CNT_W-1:0]     cmd_pages;
    logic                 ddr_valid;
    logic [WDATA_W-1:0]   ddr_data;
    logic                 page_release;
    logic [PAGE_W-1:0]    release_page;
    logic [RADDR_W-1:0]   ext_raddr;
    logic                 ext_rd;
    logic                 ext_regen;
    logic [RDATA_W-1:0]   ext_data_out;
    logic                 busy;
    logic [NUM_PAGES-1:0] page_ready;
    logic                 overrun;

    // parsed stimulus, one entry per line
    logic [7:0]           op_q[$];
    logic [31:0]          a_q[$];
    logic [31:0]          b_q[$];
    logic [31:0]          c_q[$];
    string                name_q[$];
    int                   beat_total;             // sizes the watchdog
    int                   read_total;
    logic                 stim_loaded;            // arms the watchdog

    // reference copy of the buffer, filled from the beat pattern
    logic [WDATA_W-1:0]   model_mem [0:BUF_WORDS-1];
    logic [PAGE_W-1:0]    m_page;
    logic [WADDR_W-1:0]   m_addr;
    logic [CNT_W-1:0]     m_left;                 // pages left in command

    string                test_name;
    int                   test_errors;
    int                   errors;
    int                   checks;
    int                   tests_run;
    int                   tests_failed;
    logic [RDATA_W-1:0]   last_out;               // value ext_data_out must hold

    ddr_rd_chan ddr_rd_chan_inst (.*);

    initial begin
        wclk = 1'b0;
        forever #(CLK_NS / 2) wclk = ~wclk;
    end

    // beat k of a burst, upper half base+k, lower half its inverse
    function automatic logic [WDATA_W-1:0] beat_pattern(input logic [31:0] base, input int k);
        logic [31:0] hi;
        hi = base + k;
        return {hi, ~hi};
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errors == 0) begin
                $display("PASS   %s", test_name);
            end else begin
                tests_failed++;
                $display("FAIL   %s (%0d errors)", test_name, test_errors);
            end
        end
    endtask

    task automatic load_stim(output bit ok);
        int          fd;
        int          n;
        int          need;
        string       line;
        string       op;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        beat_total = 0;
        read_total = 0;
        fd = $fopen("sim/ddr_rd_stim.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s", op);
                if (n == 1 && op[0] != "#") begin     // skip blanks and comments
                    a = '0;
                    b = '0;
                    c = '0;
                    name = "";
                    case (op[0])
                        "T": begin
                            need = 2;
                            n = $sscanf(line, "%s %s", op, name);
                        end
                        "C", "B": begin
                            need = 3;
                            n = $sscanf(line, "%s %d %h", op, a, b);  // page/count or count/base
                        end
                        "L": begin
                            need = 2;
                            n = $sscanf(line, "%s %d", op, a);
                        end
                        "R": begin
                            need = 4;
                            n = $sscanf(line, "%s %h %h %d", op, a, b, c);
                        end
                        "S": begin
                            need = 4;
                            n = $sscanf(line, "%s %h %d %d", op, a, b, c);
                        end
                        default: begin
                            need = 1;
                            n = 0;
                        end
                    endcase
                    if (n < need) begin
                        $display("stimulus line not understood: %s", line);
                        errors++;
                    end else begin
                        op_q.push_back(op[0]);
                        a_q.push_back(a);
                        b_q.push_back(b);
                        c_q.push_back(c);
                        name_q.push_back(name);
                        if (op[0] == "B") beat_total += int'(a);
                        if (op[0] == "R") read_total++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic issue_command(input logic [PAGE_W-1:0] pg, input logic [CNT_W-1:0] cnt);
        cmd_start = 1'b1;
        cmd_page  = pg;
        cmd_pages = cnt;
        @(negedge wclk);
        cmd_start = 1'b0;
        while (!busy) @(negedge wclk);            // accepted, watchdog guards
        @(negedge wclk);                          // let the wpage_set cycle pass
        m_page = pg;
        m_addr = '0;
        m_left = cnt;
    endtask

    task automatic send_beats(input int count, input logic [31:0] base);
        int                 gap;
        logic [WDATA_W-1:0] word;
        for (int k = 0; k < count; k++) begin
            gap = $urandom % 4;                   // idle cycles before this beat
            repeat (gap) @(negedge wclk);
            word      = beat_pattern(base, k);
            ddr_valid = 1'b1;
            ddr_data  = word;
            model_mem[{m_page, m_addr}] = word;
            if (m_addr == '1 && m_left > CNT_W'(1)) begin
                m_page = m_page + 1'b1;           // wraps 3 to 0
                m_left = m_left - 1'b1;
            end
            m_addr = m_addr + 1'b1;
            @(negedge wclk);
            ddr_valid = 1'b0;
        end
        while (busy) @(negedge wclk);             // command complete
    endtask

    task automatic read_word(input logic [RADDR_W-1:0] addr, input logic [RDATA_W-1:0] exp,
                             input logic regen);
        logic [WDATA_W-1:0] beat;
        logic [RDATA_W-1:0] half;
        if (regen) begin
            beat = model_mem[addr[RADDR_W-1:1]];
            half = addr[0] ? beat[WDATA_W-1:RDATA_W] : beat[RDATA_W-1:0];
            checks++;
            assert (half === exp) else begin
                $display("stim file word for address %h disagrees with the beat pattern", addr);
                errors++;
                test_errors++;
            end
        end
        ext_rd    = 1'b1;
        ext_raddr = addr;
        @(negedge wclk);
        ext_rd    = 1'b0;
        check_value("output before regen", last_out, ext_data_out);  // no early data
        ext_regen = regen;
        @(negedge wclk);
        ext_regen = 1'b0;
        check_value($sformatf("read %h", addr), exp, ext_data_out);
        last_out = exp;
    endtask

    task automatic check_status(input logic [NUM_PAGES-1:0] ready, input logic ovr,
                                input logic bsy);
        check_value("page_ready", 32'(ready), 32'(page_ready));
        check_value("overrun", 32'(ovr), 32'(overrun));
        check_value("busy", 32'(bsy), 32'(busy));
    endtask

    task automatic hand_back_page(input logic [PAGE_W-1:0] pg);
        page_release = 1'b1;
        release_page = pg;
        @(negedge wclk);
        page_release = 1'b0;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        bit          file_ok;
        rst_n        = 1'b0;
        cmd_start    = 1'b0;
        cmd_page     = '0;
        cmd_pages    = '0;
        ddr_valid    = 1'b0;
        ddr_data     = '0;
        page_release = 1'b0;
        release_page = '0;
        ext_raddr    = '0;
        ext_rd       = 1'b0;
        ext_regen    = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        test_name    = "";
        last_out     = '0;                        // output register resets to zero
        stim_loaded  = 1'b0;
        void'($urandom(32'he486_0e2b));
        load_stim(file_ok);
        if (!file_ok) begin
            $display("stimulus file sim/ddr_rd_stim.txt could not be opened");
            $display("Done: errors found");
            $finish;
        end else begin
            stim_loaded = 1'b1;
            repeat (5) @(negedge wclk);           // five rising edges in reset
            rst_n = 1'b1;
            for (int i = 0; i < op_q.size(); i++) begin
                a = a_q[i];
                b = b_q[i];
                c = c_q[i];
                case (op_q[i])
                    "T": begin
                        finish_test();
                        test_name   = name_q[i];
                        test_errors = 0;
                    end
                    "C": issue_command(a[PAGE_W-1:0], b[CNT_W-1:0]);
                    "B": send_beats(int'(a), b);
                    "R": read_word(a[RADDR_W-1:0], b, c[0]);
                    "S": check_status(a[NUM_PAGES-1:0], b[0], c[0]);
                    "L": hand_back_page(a[PAGE_W-1:0]);
                    default: ;
                endcase
            end
            finish_test();
            $display("tests %0d, failed %0d, checks %0d, errors %0d",
                     tests_run, tests_failed, checks, errors);
            if (errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

    // watchdog, a beat can trail three idle cycles so it counts four
    initial begin
        realtime limit_ns;
        wait (stim_loaded === 1'b1);
        limit_ns = real'((beat_total * 4 + read_total * 4 + op_q.size() * 4) * CLK_NS * 2);
        #(limit_ns);
        $display("watchdog expired at %0d ns, the run did not complete", $time);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- source/ddr_rd_burst_seq.sv
`timescale 1ns/1ps

module ddr_rd_burst_seq
    import ddr_rd_pkg::*;
(
    input  logic                 wclk,          // subsystem clock
    input  logic                 rst_n,         // sync, active low
    input  logic                 cmd_start,     // command pulse
    input  logic [PAGE_W-1:0]    cmd_page,      // first page of command
    input  logic [CNT_W-1:0]     cmd_pages,     // number of pages 1 to 4
    input  logic                 ddr_valid,     // one beat on ddr_data
    input  logic [WDATA_W-1:0]   ddr_data,      // beat from memory
    input  logic                 page_release,  // client done with a page
    input  logic [PAGE_W-1:0]    release_page,  // page being released
    input  logic [PAGE_W-1:0]    page,          // buffer's current write page
    input  logic                 wlast,         // buffer at beat 127
    output logic [PAGE_W-1:0]    wpage_in,      // start page to buffer
    output logic                 wpage_set,     // load start page
    output logic                 page_next,     // advance to next page
    output logic                 we,            // beat write
    output logic [WDATA_W-1:0]   data_in,       // beat data to buffer
    output logic                 busy,          // command in progress
    output logic [NUM_PAGES-1:0] page_ready,    // per page filled flag
    output logic                 overrun        // sticky flag for a refilled unreleased page
);

    logic [PAGE_W-1:0] cmd_page_r;              // latched start page
    logic [CNT_W-1:0]  pages_left;              // pages still to fill incl current
    logic              accept;                  // command taken this cycle
    logic              page_done;               // last beat of a page written
    logic              more_pages;              // another page follows
    logic              first_pend;              // next beat is beat 0 of a page

    // memory side cannot stall so data passes straight through
    assign we      = ddr_valid;
    assign data_in = ddr_data;

    assign accept     = cmd_start && !busy;     // ignored while busy
    assign page_done  = we && wlast;
    assign more_pages = pages_left > CNT_W'(1);
    assign page_next  = page_done && more_pages; // same cycle as beat 127
    assign wpage_in   = cmd_page_r;

    // command latch and page counting
    always_ff @(posedge wclk) begin
        if (!rst_n) begin
            cmd_page_r <= '0;
            pages_left <= '0;
            wpage_set  <= 1'b0;
            busy       <= 1'b0;
        end else begin
            wpage_set <= accept;                // one cycle after cmd_start
            if (accept) begin
                cmd_page_r <= cmd_page;
                pages_left <= cmd_pages;
                busy       <= 1'b1;             // rises with wpage_set
            end else if (page_done) begin
                if (more_pages) begin
                    pages_left <= pages_left - 1'b1;
                end else begin
                    pages_left <= '0;
                    busy       <= 1'b0;         // last page of command full
                end
            end
        end
    end

    // beat 0 tracking armed by either page control
    always_ff @(posedge wclk) begin
        if (!rst_n) begin
            first_pend <= 1'b0;
        end else if (wpage_set || page_next) begin
            first_pend <= 1'b1;                 // page_next wins over its own beat
        end else if (we) begin
            first_pend <= 1'b0;
        end
    end

    // ready bits and sticky overrun
    always_ff @(posedge wclk) begin
        if (!rst_n) begin
            page_ready <= '0;
            overrun    <= 1'b0;
        end else begin
            if (page_release) begin
                page_ready[release_page] <= 1'b0;
            end
            if (page_done) begin
                page_ready[page] <= 1'b1;       // fill beats a same cycle release
            end
            if (we && first_pend && page_ready[page]) begin
                overrun <= 1'b1;                // client still owns this page
            end
        end
    end

    // beats only arrive inside a command
    a_valid_in_busy: assert property (@(posedge wclk) disable iff (!rst_n)
        ddr_valid |-> busy)
        else $error("ddr_valid outside busy");

endmodule

//--- source/ddr_rd_chan.sv
`timescale 1ns/1ps

module ddr_rd_chan
    import ddr_rd_pkg::*;
(
    input  logic                 wclk,          // subsystem clock
    input  logic                 rst_n,         // sync, active low
    input  logic                 cmd_start,     // read command pulse
    input  logic [PAGE_W-1:0]    cmd_page,      // first page
    input  logic [CNT_W-1:0]     cmd_pages,     // page count
    input  logic                 ddr_valid,     // beat strobe from memory
    input  logic [WDATA_W-1:0]   ddr_data,      // beat data
    input  logic                 page_release,  // client page release
    input  logic [PAGE_W-1:0]    release_page,  // released page number
    input  logic [RADDR_W-1:0]   ext_raddr,     // client read address
    input  logic                 ext_rd,        // client read enable
    input  logic                 ext_regen,     // client output register enable
    output logic [RDATA_W-1:0]   ext_data_out,  // client read data
    output logic                 busy,          // command in progress
    output logic [NUM_PAGES-1:0] page_ready,    // filled pages
    output logic                 overrun        // sticky refill error
);

    logic [PAGE_W-1:0]  wpage_in;               // start page to buffer
    logic               wpage_set;
    logic               page_next;
    logic [PAGE_W-1:0]  page;                   // buffer's write page
    logic               wlast;
    logic               we;
    logic [WDATA_W-1:0] data_in;

    ddr_rd_burst_seq seq_inst (
        .wclk         (wclk),
        .rst_n        (rst_n),
        .cmd_start    (cmd_start),
        .cmd_page     (cmd_page),
        .cmd_pages    (cmd_pages),
        .ddr_valid    (ddr_valid),
        .ddr_data     (ddr_data),
        .page_release (page_release),
        .release_page (release_page),
        .page         (page),
        .wlast        (wlast),
        .wpage_in     (wpage_in),
        .wpage_set    (wpage_set),
        .page_next    (page_next),
        .we           (we),
        .data_in      (data_in),
        .busy         (busy),
        .page_ready   (page_ready),
        .overrun      (overrun)
    );

    mcntrl_1kx32r buf_inst (
        .wclk         (wclk),
        .rst_n        (rst_n),
        .ext_raddr    (ext_raddr),
        .ext_rd       (ext_rd),
        .ext_regen    (ext_regen),
        .ext_data_out (ext_data_out),
        .wpage_in     (wpage_in),
        .wpage_set    (wpage_set),
        .page_next    (page_next),
        .page         (page),
        .wlast        (wlast),
        .we           (we),
        .data_in      (data_in)
    );

endmodule

//--- source/ddr_rd_pkg.sv
package ddr_rd_pkg;

    // data path widths
    localparam int WDATA_W   = 64;           // one ddr beat, one ram write word
    localparam int RDATA_W   = 32;           // one external read word

    // page organisation of the buffer
    localparam int PAGE_W    = 2;            // page number bits
    localparam int NUM_PAGES = 4;            // pages in the buffer
    localparam int WADDR_W   = 7;            // beat index inside a page, 128 beats

    // derived buffer geometry
    localparam int BUF_AW    = PAGE_W + WADDR_W;  // ram write address, page over beat
    localparam int BUF_WORDS = NUM_PAGES << WADDR_W;  // 512 words of 64 bits

    // external read side
    // the top two bits select the page
    // the low eight bits pick a 32 bit half word inside it
    localparam int RADDR_W   = 10;           // 1024 words of 32 bits

    // command page count
    localparam int CNT_W     = 3;            // 1..4 pages per command

    // ram output register option
    localparam int RD_REGS   = 1;            // 1 adds the regen gated output stage

endpackage

//--- source/mcntrl_1kx32r.sv
`timescale 1ns/1ps

module mcntrl_1kx32r
    import ddr_rd_pkg::*;
(
    input  logic               wclk,          // subsystem clock
    input  logic               rst_n,         // sync, active low
    input  logic [RADDR_W-1:0] ext_raddr,     // external read address
    input  logic               ext_rd,        // external read enable
    input  logic               ext_regen,     // external output register enable
    output logic [RDATA_W-1:0] ext_data_out,  // external read data
    input  logic [PAGE_W-1:0]  wpage_in,      // page to load on wpage_set
    input  logic               wpage_set,     // load page, clear beat address
    input  logic               page_next,     // advance page, clear beat address
    output logic [PAGE_W-1:0]  page,          // current write page
    output logic               wlast,         // write address at last beat of page
    input  logic               we,            // write beat, also steps address
    input  logic [WDATA_W-1:0] data_in        // beat data
);

    logic [PAGE_W-1:0]  page_r;               // current write page
    logic [WADDR_W-1:0] waddr;                // beat index inside page

    // page register
    always_ff @(posedge wclk) begin
        if (!rst_n) begin
            page_r <= '0;
        end else if (wpage_set) begin
            page_r <= wpage_in;               // start of command
        end else if (page_next) begin
            page_r <= page_r + 1'b1;          // wraps 3 -> 0
        end
    end

    // beat address, auto increment on every write
    always_ff @(posedge wclk) begin
        if (!rst_n) begin
            waddr <= '0;
        end else if (wpage_set || page_next) begin
            waddr <= '0;                      // new page starts at beat 0
        end else if (we) begin
            waddr <= waddr + 1'b1;
        end
    end

    assign page  = page_r;
    assign wlast = &waddr;                    // beat 127

    ram_512x64w_1kx32r #(
        .REGISTERS (RD_REGS)
    ) ram_inst (
        .wclk     (wclk),
        .rst_n    (rst_n),
        .raddr    (ext_raddr),                // page over half word index
        .ren      (ext_rd),
        .regen    (ext_regen),
        .data_out (ext_data_out),
        .waddr    ({page_r, waddr}),          // page over beat index
        .we       (we),
        .data_in  (data_in)
    );

    // page load must not collide with a beat, that beat would be lost
    a_set_no_we: assert property (@(posedge wclk) disable iff (!rst_n)
        !(wpage_set && we))
        else $error("wpage_set together with we");

endmodule

//--- source/ram_512x64w_1kx32r.sv
`timescale 1ns/1ps

module ram_512x64w_1kx32r
    import ddr_rd_pkg::*;
#(
    parameter int REGISTERS = RD_REGS        // 1 adds output register after read reg
) (
    input  logic               wclk,          // single clock for both ports
    input  logic               rst_n,         // sync, active low
    input  logic [RADDR_W-1:0] raddr,         // 32 bit word address
    input  logic               ren,           // load read data register
    input  logic               regen,         // load output register
    output logic [RDATA_W-1:0] data_out,      // selected 32 bit half
    input  logic [BUF_AW-1:0]  waddr,         // 64 bit word address
    input  logic               we,            // write enable, full word
    input  logic [WDATA_W-1:0] data_in        // write data
);

    logic [WDATA_W-1:0] mem [0:BUF_WORDS-1];  // storage array, not reset

    logic [WDATA_W-1:0] rd_word;              // read data register, full word
    logic               rd_hi;                // low raddr bit held from ren cycle
    logic [RDATA_W-1:0] rd_half;              // half selected from rd_word

    // write port
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr] <= data_in;            // whole 64 bit word
        end
    end

    // read port, one 64 bit word per pair of 32 bit addresses
    always_ff @(posedge wclk) begin
        if (!rst_n) begin
            rd_word <= '0;
            rd_hi   <= 1'b0;
        end else if (ren) begin
            rd_word <= mem[raddr[RADDR_W-1:1]]; // drop half select bit
            rd_hi   <= raddr[0];              // odd word is upper half
        end
    end

    // even word low half, odd word high half
    assign rd_half = rd_hi ? rd_word[WDATA_W-1:RDATA_W] : rd_word[RDATA_W-1:0];

    generate
        if (REGISTERS == 1) begin : g_out_reg
            logic [RDATA_W-1:0] out_r;        // output register

            always_ff @(posedge wclk) begin
                if (!rst_n) begin
                    out_r <= '0;
                end else if (regen) begin
                    out_r <= rd_half;         // holds while regen low
                end
            end

            assign data_out = out_r;          // valid two cycles after ren
        end else begin : g_no_out_reg
            assign data_out = rd_half;        // valid one cycle after ren
        end
    endgenerate

    // address must be clean whenever a read is requested
    a_raddr_known: assert property (@(posedge wclk) disable iff (!rst_n)
        ren |-> !$isunknown(raddr))
        else $error("ram read with unknown address");

endmodule
